// File: hdl/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Boot address, in the flash region.
`define FETCH_RESET_PC        32'h3000_0000

`define FETCH_LINE_BYTES      16              // Four words per refill.
`define FETCH_ICACHE_LINES    16              // Direct-mapped sets.
`define FETCH_TAG_BITS        26              // Tag taken from pc[31:6].

// Lines inside this window are read as one incrementing burst.
`define FETCH_SDRAM_BASE      32'hA000_0000
`define FETCH_SDRAM_END       32'hBFFF_FFFF

`define FETCH_QUEUE_DEPTH     4               // Packets buffered toward decode.

// AXI field encodings used by the read master.
`define FETCH_AXI_SIZE_WORD   3'b010
`define FETCH_AXI_BURST_FIXED 2'b00
`define FETCH_AXI_BURST_INCR  2'b01
`define FETCH_AXI_RESP_OKAY   2'b00

`endif

// File: hdl/fetch_pkg.sv
`include "fetch_macros.svh"

package fetch_pkg;

    // Packet handed to decode.
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;           // Zero when fault is set.
        logic        fault;          // Non-OKAY response on the refill.
    } fetch_pkt_t;

    // One beat of the AXI read data channel.
    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
    } rd_beat_t;

    // AXI read address channel fields.
    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } ar_req_t;

    // Word 0 sits in the low 32 bits.
    typedef logic [`FETCH_LINE_BYTES/4-1:0][31:0] line_t;

    // Line write into the instruction cache.
    typedef struct packed {
        logic [$clog2(`FETCH_ICACHE_LINES)-1:0] index;
        logic [`FETCH_TAG_BITS-1:0]             tag;
        line_t                                  data;
    } fill_t;

endpackage

// File: hdl/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo #(
    parameter type T     = logic [31:0],
    parameter int  DEPTH = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic in_valid,
    output logic in_ready,
    input  T     in_data,
    output logic out_valid,
    input  logic out_ready,
    output T     out_data
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T               mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [CW-1:0]  count;
    logic           running;                  // Set once reset has been released.
    logic           push;
    logic           pop;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready  = running && (count != CW'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running <= 1'b0;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
        end else begin
            running <= 1'b1;
            if (flush) begin
                wr_ptr <= '0;                     // Flush beats a same-cycle push.
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (push) wr_ptr <= next_ptr(wr_ptr);
                if (pop)  rd_ptr <= next_ptr(rd_ptr);
                if (push && !pop) count <= count + 1'b1;
                else if (pop && !push) count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= in_data;
    end

endmodule

// File: hdl/icache.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module icache (
    input  logic            clk,
    input  logic            rst,
    input  logic [31:0]     lookup_pc,
    output logic            hit,
    output logic [31:0]     hit_inst,
    input  logic            fill_en,
    input  fetch_pkg::fill_t fill
);
    import fetch_pkg::*;

    localparam int SETS       = `FETCH_ICACHE_LINES;
    localparam int INDEX_BITS = $clog2(SETS);
    localparam int WORD_BITS  = $clog2(`FETCH_LINE_BYTES / 4);
    localparam int OFFSET     = $clog2(`FETCH_LINE_BYTES);
    localparam int TAG_BITS   = `FETCH_TAG_BITS;

    logic [SETS-1:0]     valid;
    logic [TAG_BITS-1:0] tags [SETS];
    line_t               lines [SETS];

    logic [INDEX_BITS-1:0] index;
    logic [WORD_BITS-1:0]  word;
    logic [TAG_BITS-1:0]   tag;
    line_t                 line;

    // Address split for the lookup port.
    assign index = lookup_pc[OFFSET +: INDEX_BITS];
    assign word  = lookup_pc[2 +: WORD_BITS];
    assign tag   = lookup_pc[31 -: TAG_BITS];   // Overlaps the upper index bits.

    assign line     = lines[index];
    assign hit      = valid[index] && (tags[index] == tag);
    assign hit_inst = line[word];

    // Only the valid bits carry reset state.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (fill_en) begin
            valid[fill.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tags[fill.index]  <= fill.tag;
            lines[fill.index] <= fill.data;
        end
    end

endmodule

// File: hdl/ifu.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module ifu (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  redirect,
    input  logic [31:0]           redirect_pc,
    output logic [31:0]           lookup_pc,
    input  logic                  hit,
    input  logic [31:0]           hit_inst,
    output logic                  fill_en,
    output fetch_pkg::fill_t      fill,
    output logic                  ar_valid,
    input  logic                  ar_ready,
    output fetch_pkg::ar_req_t    ar,
    input  logic                  beat_valid,
    output logic                  beat_ready,
    input  fetch_pkg::rd_beat_t   beat,
    output logic                  pkt_valid,
    input  logic                  pkt_ready,
    output fetch_pkg::fetch_pkt_t pkt,
    output logic                  flush
);
    import fetch_pkg::*;

    localparam int LINE_WORDS = `FETCH_LINE_BYTES / 4;
    localparam int OB         = $clog2(`FETCH_LINE_BYTES);
    localparam int CW         = $clog2(LINE_WORDS);
    localparam int PW         = $clog2(LINE_WORDS + 1);
    localparam int IB         = $clog2(`FETCH_ICACHE_LINES);

    typedef enum logic [1:0] {IDLE, ADDR, DATA, DRAIN} state_t;

    state_t         state;
    logic [31:0]    pc;
    logic [CW-1:0]  beat_cnt;
    logic [PW-1:0]  pend;                     // Beats still owed by the slave.
    logic           fault_q;
    logic           discard_q;
    ar_req_t        ar_q;
    logic [31:OB]   line_addr;
    line_t          line_q;
    line_t          fill_line;

    logic [31:0]    line_base;
    logic           is_sdram;
    logic           burst_mode;
    logic           pop;
    logic           beat_ok;
    logic [PW-1:0]  pend_after;
    logic           line_done;
    logic [CW-1:0]  next_word;
    logic           issue;
    logic           reissue;

    assign line_base  = {pc[31:OB], {OB{1'b0}}};
    assign is_sdram   = (line_base >= `FETCH_SDRAM_BASE) && (line_base <= `FETCH_SDRAM_END);
    assign burst_mode = (ar_q.burst == `FETCH_AXI_BURST_INCR);
    assign beat_ready = (state == DATA) || (state == DRAIN);
    assign pop        = beat_valid && beat_ready;
    assign beat_ok    = (beat.resp == `FETCH_AXI_RESP_OKAY);
    assign pend_after = pend - {{(PW-1){1'b0}}, pop};
    assign next_word  = beat_cnt + 1'b1;
    assign line_done  = burst_mode ? beat.last : (beat_cnt == CW'(LINE_WORDS - 1));

    // Start of a refill, and the next single-beat request in flash.
    assign issue   = (state == IDLE) && !redirect && !fault_q && !hit;
    assign reissue = (state == DATA) && !redirect && pop && beat_ok && !line_done && !burst_mode;

    assign lookup_pc = pc;
    assign flush     = redirect;
    assign ar        = ar_q;

    assign pkt_valid = (state == IDLE) && !redirect && (fault_q || hit);
    assign pkt.pc    = pc;
    assign pkt.inst  = fault_q ? 32'h0 : hit_inst;
    assign pkt.fault = fault_q;

    // The last word goes straight from the beat into the fill.
    always_comb begin
        fill_line           = line_q;
        fill_line[beat_cnt] = beat.data;
    end

    assign fill_en    = (state == DATA) && !redirect && pop && beat_ok && line_done;
    assign fill.index = line_addr[OB +: IB];
    assign fill.tag   = line_addr[31 -: `FETCH_TAG_BITS];
    assign fill.data  = fill_line;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            pc        <= `FETCH_RESET_PC;
            ar_valid  <= 1'b0;
            beat_cnt  <= '0;
            pend      <= '0;
            fault_q   <= 1'b0;
            discard_q <= 1'b0;
        end else begin
            if (pop) pend <= pend_after;
            case (state)
                IDLE: begin
                    if (redirect) begin
                        pc      <= redirect_pc;
                        fault_q <= 1'b0;
                    end else if (fault_q || hit) begin
                        if (pkt_ready) begin
                            pc      <= pc + 32'd4;
                            fault_q <= 1'b0;
                        end
                    end else begin
                        ar_valid  <= 1'b1;
                        beat_cnt  <= '0;
                        discard_q <= 1'b0;
                        state     <= ADDR;
                    end
                end
                ADDR: begin
                    if (redirect) begin
                        pc        <= redirect_pc;
                        discard_q <= 1'b1;           // Request must still complete.
                    end
                    if (ar_ready) begin
                        ar_valid <= 1'b0;
                        pend     <= burst_mode ? PW'(LINE_WORDS) : PW'(1);
                        state    <= (discard_q || redirect) ? DRAIN : DATA;
                    end
                end
                DATA: begin
                    if (redirect) begin
                        pc    <= redirect_pc;
                        state <= (pend_after != '0) ? DRAIN : IDLE;
                    end else if (pop) begin
                        if (!beat_ok) begin
                            fault_q <= 1'b1;
                            state   <= (pend_after != '0) ? DRAIN : IDLE;
                        end else begin
                            beat_cnt <= next_word;
                            if (line_done) begin
                                state <= IDLE;
                            end else if (!burst_mode) begin
                                ar_valid <= 1'b1;
                                state    <= ADDR;
                            end
                        end
                    end
                end
                DRAIN: begin
                    if (redirect) begin
                        pc      <= redirect_pc;
                        fault_q <= 1'b0;
                    end
                    if (pop && (pend == PW'(1))) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Request fields and line words.
    always_ff @(posedge clk) begin
        if (issue) begin
            line_addr   <= pc[31:OB];
            ar_q.addr   <= line_base;
            ar_q.len    <= is_sdram ? 8'(LINE_WORDS - 1) : 8'd0;
            ar_q.size   <= `FETCH_AXI_SIZE_WORD;
            ar_q.burst  <= is_sdram ? `FETCH_AXI_BURST_INCR : `FETCH_AXI_BURST_FIXED;
        end else if (reissue) begin
            ar_q.addr   <= {line_addr, next_word, 2'b00};
        end
        if ((state == DATA) && pop && beat_ok) line_q[beat_cnt] <= beat.data;
    end

endmodule

// File: hdl/fetch_top.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  redirect,
    input  logic [31:0]           redirect_pc,
    output logic                  ar_valid,
    input  logic                  ar_ready,
    output fetch_pkg::ar_req_t    ar,
    input  logic                  r_valid,
    output logic                  r_ready,
    input  logic [31:0]           r_data,
    input  logic [1:0]            r_resp,
    input  logic                  r_last,
    output logic                  out_valid,
    input  logic                  out_ready,
    output fetch_pkg::fetch_pkt_t out_pkt
);
    import fetch_pkg::*;

    rd_beat_t   r_beat;
    rd_beat_t   beat;
    logic       beat_valid;
    logic       beat_ready;
    fetch_pkt_t pkt;
    logic       pkt_valid;
    logic       pkt_ready;
    logic       flush;
    logic [31:0] lookup_pc;
    logic       hit;
    logic [31:0] hit_inst;
    logic       fill_en;
    fill_t      fill;

    assign r_beat.data = r_data;
    assign r_beat.resp = r_resp;
    assign r_beat.last = r_last;

    ifu i_ifu (
        .clk(clk), .rst(rst),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .lookup_pc(lookup_pc), .hit(hit), .hit_inst(hit_inst),
        .fill_en(fill_en), .fill(fill),
        .ar_valid(ar_valid), .ar_ready(ar_ready), .ar(ar),
        .beat_valid(beat_valid), .beat_ready(beat_ready), .beat(beat),
        .pkt_valid(pkt_valid), .pkt_ready(pkt_ready), .pkt(pkt),
        .flush(flush)
    );

    icache i_icache (
        .clk(clk), .rst(rst),
        .lookup_pc(lookup_pc), .hit(hit), .hit_inst(hit_inst),
        .fill_en(fill_en), .fill(fill)
    );

    // Read beats are never flushed; the fetch unit drains them itself.
    stream_fifo #(.T(rd_beat_t), .DEPTH(2)) i_beat_fifo (
        .clk(clk), .rst(rst), .flush(1'b0),
        .in_valid(r_valid), .in_ready(r_ready), .in_data(r_beat),
        .out_valid(beat_valid), .out_ready(beat_ready), .out_data(beat)
    );

    stream_fifo #(.T(fetch_pkt_t), .DEPTH(`FETCH_QUEUE_DEPTH)) i_pkt_fifo (
        .clk(clk), .rst(rst), .flush(flush),
        .in_valid(pkt_valid), .in_ready(pkt_ready), .in_data(pkt),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(out_pkt)
    );

endmodule

// File: verification/fetch_chk.sv
`timescale 1ns/1ps

module fetch_chk (
    input logic                  clk,
    input logic                  rst,
    input logic                  redirect,
    input logic                  ar_valid,
    input logic                  ar_ready,
    input fetch_pkg::ar_req_t    ar,
    input logic                  r_ready,
    input logic                  out_valid,
    input logic                  out_ready,
    input fetch_pkg::fetch_pkt_t out_pkt
);
    int fail_count = 0;

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
        else begin
            fail_count++;
            $error("ar request dropped or changed before ar_ready");
        end

    // Only a flush may take a waiting packet away.
    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready && !redirect |=> out_valid && $stable(out_pkt))
        else begin
            fail_count++;
            $error("out_pkt dropped or changed under back-pressure");
        end

    a_ctrl_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown({ar_valid, r_ready, out_valid}))
        else begin
            fail_count++;
            $error("handshake signal unknown after reset");
        end

    a_payload_known: assert property (@(posedge clk) disable iff (rst)
        (!ar_valid || !$isunknown(ar)) && (!out_valid || !$isunknown(out_pkt)))
        else begin
            fail_count++;
            $error("valid payload holds unknown bits");
        end

endmodule

bind fetch_top fetch_chk i_fetch_chk (
    .clk(clk), .rst(rst), .redirect(redirect),
    .ar_valid(ar_valid), .ar_ready(ar_ready), .ar(ar), .r_ready(r_ready),
    .out_valid(out_valid), .out_ready(out_ready), .out_pkt(out_pkt)
);

// File: verification/fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_tb;
    import fetch_pkg::*;

    localparam int          TOTAL_PKTS     = 54;
    localparam int          TIMEOUT_CYCLES = 200 * TOTAL_PKTS + 1000;
    localparam logic [31:0] ERR_LINE       = 32'h3000_0100;   // Slave answers SLVERR here.

    logic        clk = 1'b0;
    logic        rst, redirect, ar_valid, ar_ready, r_valid, r_ready, r_last;
    logic        out_valid, out_ready;
    logic [31:0] redirect_pc, r_data;
    logic [1:0]  r_resp;
    ar_req_t     ar;
    fetch_pkt_t  out_pkt;

    integer      seed = 14;
    int          value_errs = 0;
    int          assert_fails = 0;
    int          rx_count = 0;
    int          gap = 0;
    logic        active = 1'b0;
    logic        r_taken = 1'b0;
    logic [31:0] exp_pc = `FETCH_RESET_PC;
    ar_req_t     ar_log [$];
    rd_beat_t    beat_q [$];

    fetch_top i_fetch_top (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return (addr ^ 32'h5A5A_5A5A) & ~32'h3;
    endfunction

    function automatic logic in_err_line(input logic [31:0] addr);
        return (addr & ~32'hF) == ERR_LINE;
    endfunction

    function automatic fetch_pkt_t expect_pkt(input logic [31:0] pc);
        fetch_pkt_t p;
        p.pc    = pc;
        p.fault = in_err_line(pc);
        p.inst  = p.fault ? 32'h0 : mem_word(pc);
        return p;
    endfunction

    function automatic ar_req_t make_ar(input logic [31:0] addr, input logic [7:0] len,
                                        input logic [1:0] burst);
        ar_req_t a;
        a.addr  = addr;
        a.len   = len;
        a.size  = `FETCH_AXI_SIZE_WORD;
        a.burst = burst;
        return a;
    endfunction

    // Requests logged from index from on whose address lies in the line at base.
    function automatic int count_line(input int from, input logic [31:0] base);
        int n;
        n = 0;
        for (int i = from; i < ar_log.size(); i++) begin
            if (ar_log[i].addr[31:4] == base[31:4]) n++;
        end
        return n;
    endfunction

    task automatic check_pkt(input fetch_pkt_t got, input fetch_pkt_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERR %0t: packet pc=%h inst=%h fault=%b, expected pc=%h inst=%h fault=%b",
                     $time, got.pc, got.inst, got.fault, exp.pc, exp.inst, exp.fault);
        end
    endtask

    task automatic check_ar(input ar_req_t got, input ar_req_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERR %0t: ar addr=%h len=%0d burst=%0d, expected addr=%h len=%0d burst=%0d",
                     $time, got.addr, got.len, got.burst, exp.addr, exp.len, exp.burst);
        end
    endtask

    task automatic check_req_count(input int got, input int exp, input logic [31:0] line);
        if (got != exp) begin
            value_errs++;
            $display("ERR %0t: %0d read requests for line %h, expected %0d",
                     $time, got, line, exp);
        end
    endtask

    task automatic queue_beats(input ar_req_t req);
        rd_beat_t    b;
        logic [31:0] addr;
        for (int i = 0; i <= int'(req.len); i++) begin
            addr   = (req.burst == `FETCH_AXI_BURST_INCR) ? req.addr + 32'(4 * i) : req.addr;
            b.resp = in_err_line(addr) ? 2'b10 : `FETCH_AXI_RESP_OKAY;
            b.data = in_err_line(addr) ? 32'h0 : mem_word(addr);
            b.last = (i == int'(req.len));
            beat_q.push_back(b);
        end
    endtask

    task automatic wait_packets(input int n);
        int target;
        target = rx_count + n;
        while (rx_count < target) @(negedge clk);
    endtask

    task automatic send_redirect(input logic [31:0] target, output int mark);
        redirect    = 1'b1;
        redirect_pc = target;
        mark        = ar_log.size();
        @(negedge clk);
        redirect    = 1'b0;
    endtask

    // AXI slave sampling side, ahead of any DUT update.
    always @(posedge clk) begin
        active = !rst;
        if (!rst) begin
            if (r_valid && r_ready) begin
                void'(beat_q.pop_front());
                r_taken = 1'b1;
            end
            if (ar_valid && ar_ready) begin
                if (beat_q.size() == 0) gap = $unsigned($random(seed)) % 4;
                ar_log.push_back(ar);
                queue_beats(ar);
            end
        end
    end

    always @(negedge clk) begin
        if (active) begin
            ar_ready  = ($unsigned($random(seed)) % 4) != 0;
            out_ready = ($unsigned($random(seed)) % 4) != 0;   // Roughly 25% stall.
            if (r_taken) begin
                r_valid = 1'b0;
                r_taken = 1'b0;
                gap     = $unsigned($random(seed)) % 4;
            end
            if (!r_valid && beat_q.size() > 0) begin
                if (gap == 0) begin
                    {r_data, r_resp, r_last} = beat_q[0];
                    r_valid = 1'b1;
                end else begin
                    gap--;
                end
            end
        end
    end

    // Expected PC follows the stream; a redirect restarts it at the target.
    always @(posedge clk) begin
        if (!rst) begin
            if (out_valid && out_ready) begin
                check_pkt(out_pkt, expect_pkt(exp_pc));
                exp_pc   = exp_pc + 32'd4;
                rx_count = rx_count + 1;
            end
            if (redirect) exp_pc = redirect_pc;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the fetch stream stalled after %0d packets", rx_count);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int mark;
        rst         = 1'b1;
        redirect    = 1'b0;
        redirect_pc = 32'h0;
        ar_ready    = 1'b0;
        r_valid     = 1'b0;
        r_data      = 32'h0;
        r_resp      = 2'b00;
        r_last      = 1'b0;
        out_ready   = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Flash lines come in as four single-beat reads.
        wait_packets(28);
        for (int i = 0; i < 4; i++) begin
            check_ar(ar_log[i], make_ar(`FETCH_RESET_PC + 32'(4 * i), 8'd0,
                                        `FETCH_AXI_BURST_FIXED));
        end
        check_req_count(count_line(0, `FETCH_RESET_PC), 4, `FETCH_RESET_PC);

        send_redirect(`FETCH_SDRAM_BASE, mark);
        wait_packets(8);
        check_req_count(count_line(mark, `FETCH_SDRAM_BASE), 1, `FETCH_SDRAM_BASE);
        for (int i = mark; i < ar_log.size(); i++) begin
            if ((ar_log[i].addr & ~32'hF) == `FETCH_SDRAM_BASE) begin
                check_ar(ar_log[i], make_ar(`FETCH_SDRAM_BASE, 8'd3, `FETCH_AXI_BURST_INCR));
            end
        end

        // Sets 5 and 6 still hold the flash lines.
        send_redirect(32'h3000_0050, mark);
        wait_packets(8);
        check_req_count(count_line(mark, 32'h3000_0050), 0, 32'h3000_0050);
        check_req_count(count_line(mark, 32'h3000_0060), 0, 32'h3000_0060);

        send_redirect(ERR_LINE, mark);
        wait_packets(6);
        check_req_count(count_line(mark, ERR_LINE), 4, ERR_LINE);
        send_redirect(ERR_LINE + 32'd4, mark);
        wait_packets(4);
        check_req_count(count_line(mark, ERR_LINE), 3, ERR_LINE);

        assert_fails = i_fetch_top.i_fetch_chk.fail_count;
        $display("Summary: %0d packets, %0d value errors, %0d assertion failures",
                 rx_count, value_errs, assert_fails);
        if (value_errs + assert_fails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: fetch_subsystem.f
+incdir+hdl
hdl/fetch_pkg.sv
hdl/stream_fifo.sv
hdl/icache.sv
hdl/ifu.sv
hdl/fetch_top.sv
verification/fetch_chk.sv
verification/fetch_tb.sv

// File: Makefile
TOOL       := verilator
TOP        := fetch_tb
FILELIST   := fetch_subsystem.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
RUN_FLAGS  := +verilator+error+limit+1000
PASS_MSG   := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
